// ==== include/secv_defines.svh ====
// SEC-V core parameters
`ifndef SECV_DEFINES_SVH
`define SECV_DEFINES_SVH

// Data path width
`define SECV_XLEN 32

// Byte address widths of the two buses
// 8 bits reach 64 words each
`define SECV_IADR_WIDTH 8
`define SECV_DADR_WIDTH 8

// First fetch address after reset
`define SECV_RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define SECV_INST_NOP 32'h0000_0013

`endif

// ==== rtl/secv_alu.sv ====
// SEC-V arithmetic logic unit
`timescale 1ns/1ps
`include "secv_defines.svh"

module secv_alu
    import secv_fu_pkg::*;
(
    input  funit_in_t  fu_i,
    output funit_out_t fu_o
);
    logic [4:0] shamt;
    logic       lt;

    // Shift amount from the low bits only
    assign shamt = fu_i.src2[4:0];
    assign lt    = $signed(fu_i.src1) < $signed(fu_i.src2);

    // Result in the same cycle
    assign fu_o.rdy = fu_i.ena;

    always_comb begin
        case (fu_i.alu_op)
            ALU_ADD: fu_o.res = fu_i.src1 + fu_i.src2;
            ALU_SUB: fu_o.res = fu_i.src1 - fu_i.src2;
            ALU_AND: fu_o.res = fu_i.src1 & fu_i.src2;
            ALU_OR:  fu_o.res = fu_i.src1 | fu_i.src2;
            ALU_XOR: fu_o.res = fu_i.src1 ^ fu_i.src2;
            // Signed compare, 0 or 1
            ALU_SLT: fu_o.res = {{(`SECV_XLEN-1){1'b0}}, lt};
            ALU_SLL: fu_o.res = fu_i.src1 << shamt;
            // Logical, zero fill
            ALU_SRL: fu_o.res = fu_i.src1 >> shamt;
            default: fu_o.res = '0;
        endcase
    end

endmodule

// ==== rtl/secv_core.sv ====
// SEC-V processor core
`timescale 1ns/1ps
`include "secv_defines.svh"

module secv_core
    import secv_isa_pkg::*;
    import secv_fu_pkg::*;
(
    input  logic                        clk_i,
    input  logic                        rst_i,
    // Instruction bus
    output logic                        imem_cyc_o,
    output logic                        imem_stb_o,
    output logic [`SECV_IADR_WIDTH-1:0] imem_adr_o,
    input  logic [31:0]                 imem_dat_i,
    input  logic                        imem_ack_i,
    // Data bus
    output logic                        dmem_cyc_o,
    output logic                        dmem_stb_o,
    output logic [`SECV_DADR_WIDTH-1:0] dmem_adr_o,
    output logic                        dmem_we_o,
    output logic [`SECV_XLEN-1:0]       dmem_dat_o,
    input  logic [`SECV_XLEN-1:0]       dmem_dat_i,
    input  logic                        dmem_ack_i
);
    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_DECODE, ST_EXECUTE, ST_WB
    } state_t;

    state_t                state, state_next;
    logic [`SECV_XLEN-1:0] pc, pc_next, pc_plus4;
    inst_t                 ir, ir_next;
    logic [`SECV_XLEN-1:0] res_q;

    // Register file and decoder wiring
    logic [`SECV_XLEN-1:0] rs1_dat, rs2_dat, rd_dat, imm;
    regadr_t               rs1_adr, rs2_adr, rd_adr;
    logic                  rd_wb;
    funit_t                funit;
    alu_op_t               alu_op;
    src2_sel_t             src2_sel;
    rd_sel_t               rd_sel;
    logic                  is_store, is_branch, is_jump, dec_err;
    logic                  brn_take, redirect;

    // Function unit bus
    funit_in_t             fui;
    funit_out_t            fuo;
    funit_in_t             fui_bus [FUNIT_COUNT];
    funit_out_t            fuo_bus [FUNIT_COUNT];

    secv_gpr gpr_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .rs1_adr_i (rs1_adr),
        .rs1_dat_o (rs1_dat),
        .rs2_adr_i (rs2_adr),
        .rs2_dat_o (rs2_dat),
        .rd_adr_i  (rd_adr),
        .rd_dat_i  (rd_dat),
        .rd_wb_i   (rd_wb)
    );

    secv_decoder dec_i (
        .inst_i      (ir),
        .rs1_adr_o   (rs1_adr),
        .rs2_adr_o   (rs2_adr),
        .rd_adr_o    (rd_adr),
        .imm_o       (imm),
        .funit_o     (funit),
        .alu_op_o    (alu_op),
        .is_store_o  (is_store),
        .src2_sel_o  (src2_sel),
        .rd_sel_o    (rd_sel),
        .is_branch_o (is_branch),
        .is_jump_o   (is_jump),
        .err_o       (dec_err)
    );

    secv_alu alu_i (
        .fu_i (fui_bus[FUNIT_ALU]),
        .fu_o (fuo_bus[FUNIT_ALU])
    );

    secv_lsu lsu_i (
        .fu_i       (fui_bus[FUNIT_LSU]),
        .fu_o       (fuo_bus[FUNIT_LSU]),
        .dmem_cyc_o (dmem_cyc_o),
        .dmem_stb_o (dmem_stb_o),
        .dmem_adr_o (dmem_adr_o),
        .dmem_we_o  (dmem_we_o),
        .dmem_dat_o (dmem_dat_o),
        .dmem_dat_i (dmem_dat_i),
        .dmem_ack_i (dmem_ack_i)
    );

    // Request for the selected unit, enabled through EXECUTE
    always_comb begin
        fui          = FUNIT_IN_DEFAULT;
        fui.ena      = (state == ST_EXECUTE);
        fui.alu_op   = alu_op;
        fui.is_store = is_store;
        fui.src1     = rs1_dat;
        fui.src2     = (src2_sel == SRC2_IMM) ? imm : rs2_dat;
        fui.sdat     = rs2_dat;
    end

    // Other unit sees an idle request
    always_comb begin
        for (int idx = 0; idx < FUNIT_COUNT; idx++) begin
            fui_bus[idx] = FUNIT_IN_DEFAULT;
        end
        fui_bus[funit] = fui;
    end

    assign fuo = fuo_bus[funit];

    // Signed branch compare
    always_comb begin
        case (ir.b.funct3)
            F3_BEQ:  brn_take = (rs1_dat == rs2_dat);
            F3_BNE:  brn_take = (rs1_dat != rs2_dat);
            F3_BLT:  brn_take = ($signed(rs1_dat) < $signed(rs2_dat));
            F3_BGE:  brn_take = ($signed(rs1_dat) >= $signed(rs2_dat));
            default: brn_take = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + 32'd4;
    assign redirect = !dec_err && (is_jump || (is_branch && brn_take));

    // Fetch request held for the whole FETCH state
    assign imem_cyc_o = (state == ST_FETCH);
    assign imem_stb_o = (state == ST_FETCH);
    assign imem_adr_o = pc[`SECV_IADR_WIDTH-1:0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= ST_IDLE;
            pc    <= `SECV_RESET_PC;
            ir    <= `SECV_INST_NOP;
        end else begin
            state <= state_next;
            pc    <= pc_next;
            ir    <= ir_next;
        end
    end

    // Unit result kept for WB
    always_ff @(posedge clk_i) begin
        if (state == ST_EXECUTE && fuo.rdy) begin
            res_q <= fuo.res;
        end
    end

    always_comb begin
        state_next = state;
        pc_next    = pc;
        ir_next    = ir;
        rd_dat     = '0;
        rd_wb      = 1'b0;

        case (state)
            ST_IDLE: state_next = ST_FETCH;
            ST_FETCH: begin
                if (imem_ack_i) begin
                    ir_next    = imem_dat_i;
                    state_next = ST_DECODE;
                end
            end
            ST_DECODE: state_next = ST_EXECUTE;
            // Memory ops wait here for the data bus ack
            ST_EXECUTE: begin
                if (fuo.rdy) begin
                    state_next = ST_WB;
                end
            end
            ST_WB: begin
                state_next = ST_FETCH;
                pc_next    = redirect ? pc + imm : pc_plus4;
                // Illegal words write nothing
                rd_wb      = !dec_err && (rd_sel != RD_NONE);
                case (rd_sel)
                    RD_FU:   rd_dat = res_q;
                    RD_IMM:  rd_dat = imm;
                    RD_PC4:  rd_dat = pc_plus4;
                    default: rd_dat = '0;
                endcase
            end
            default: state_next = ST_IDLE;
        endcase
    end

endmodule

// ==== rtl/secv_decoder.sv ====
// SEC-V instruction decoder
`timescale 1ns/1ps
`include "secv_defines.svh"

module secv_decoder
    import secv_isa_pkg::*;
    import secv_fu_pkg::*;
(
    input  inst_t                 inst_i,
    output regadr_t               rs1_adr_o,
    output regadr_t               rs2_adr_o,
    output regadr_t               rd_adr_o,
    output logic [`SECV_XLEN-1:0] imm_o,
    output funit_t                funit_o,
    output alu_op_t               alu_op_o,
    output logic                  is_store_o,
    output src2_sel_t             src2_sel_o,
    output rd_sel_t               rd_sel_o,
    output logic                  is_branch_o,
    output logic                  is_jump_o,
    output logic                  err_o
);
    logic [`SECV_XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    opcode_t               opcode;
    logic                  f7_base;
    logic                  f7_alt;

    // Register fields sit at the same place in every format
    assign rs1_adr_o = inst_i.r.rs1;
    assign rs2_adr_o = inst_i.r.rs2;
    assign rd_adr_o  = inst_i.r.rd;

    assign opcode  = inst_i.r.opcode;
    assign f7_base = (inst_i.r.funct7 == F7_BASE);
    assign f7_alt  = (inst_i.r.funct7 == F7_ALT);

    // Sign-extended immediates
    assign imm_i = {{20{inst_i.i.imm_11_0[11]}}, inst_i.i.imm_11_0};
    assign imm_s = {{20{inst_i.s.imm_11_5[6]}}, inst_i.s.imm_11_5, inst_i.s.imm_4_0};
    assign imm_b = {{20{inst_i.b.imm_12}}, inst_i.b.imm_11, inst_i.b.imm_10_5,
                    inst_i.b.imm_4_1, 1'b0};
    assign imm_u = {inst_i.u.imm_31_12, 12'b0};
    assign imm_j = {{12{inst_i.j.imm_20}}, inst_i.j.imm_19_12, inst_i.j.imm_11,
                    inst_i.j.imm_10_1, 1'b0};

    always_comb begin
        // Plain ADD on the ALU, no side effects
        imm_o       = '0;
        funit_o     = FUNIT_ALU;
        alu_op_o    = ALU_ADD;
        is_store_o  = 1'b0;
        src2_sel_o  = SRC2_REG;
        rd_sel_o    = RD_NONE;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        err_o       = 1'b0;

        case (opcode)
            OPC_OP, OPC_OP_IMM: begin
                rd_sel_o = RD_FU;
                if (opcode == OPC_OP_IMM) begin
                    src2_sel_o = SRC2_IMM;
                    imm_o      = imm_i;
                end
                case (inst_i.r.funct3)
                    F3_ADD_SUB: alu_op_o = (opcode == OPC_OP && f7_alt) ? ALU_SUB : ALU_ADD;
                    F3_SLL:     alu_op_o = ALU_SLL;
                    F3_SLT:     alu_op_o = ALU_SLT;
                    F3_XOR:     alu_op_o = ALU_XOR;
                    F3_SRL:     alu_op_o = ALU_SRL;
                    F3_OR:      alu_op_o = ALU_OR;
                    F3_AND:     alu_op_o = ALU_AND;
                    default:    err_o = 1'b1;
                endcase
                // Register forms want base funct7 except SUB
                if (opcode == OPC_OP && !f7_base &&
                    !(inst_i.r.funct3 == F3_ADD_SUB && f7_alt)) begin
                    err_o = 1'b1;
                end
                // Shift immediates carry funct7 in imm[11:5]
                if (opcode == OPC_OP_IMM && !f7_base &&
                    (inst_i.r.funct3 == F3_SLL || inst_i.r.funct3 == F3_SRL)) begin
                    err_o = 1'b1;
                end
            end
            OPC_LUI: begin
                imm_o    = imm_u;
                rd_sel_o = RD_IMM;
            end
            OPC_JAL: begin
                imm_o     = imm_j;
                rd_sel_o  = RD_PC4;
                is_jump_o = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o       = imm_b;
                is_branch_o = 1'b1;
                case (inst_i.b.funct3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE: err_o = 1'b0;
                    default: err_o = 1'b1;
                endcase
            end
            OPC_LOAD, OPC_STORE: begin
                imm_o      = (opcode == OPC_STORE) ? imm_s : imm_i;
                src2_sel_o = SRC2_IMM;
                is_store_o = (opcode == OPC_STORE);
                rd_sel_o   = (opcode == OPC_STORE) ? RD_NONE : RD_FU;
                // Bad width never reaches the data bus
                if (inst_i.i.funct3 == F3_WORD) begin
                    funit_o = FUNIT_LSU;
                end else begin
                    err_o = 1'b1;
                end
            end
            default: err_o = 1'b1;
        endcase
    end

endmodule

// ==== rtl/secv_fu_pkg.sv ====
// SEC-V function unit types
`include "secv_defines.svh"

package secv_fu_pkg;

    // Unit select, also the index into the unit bus
    typedef enum logic {
        FUNIT_ALU = 1'b0,
        FUNIT_LSU = 1'b1
    } funit_t;
    localparam int FUNIT_COUNT = 2;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
        ALU_XOR, ALU_SLT, ALU_SLL, ALU_SRL
    } alu_op_t;

    // Second operand source
    typedef enum logic {
        SRC2_REG,
        SRC2_IMM
    } src2_sel_t;

    // Write-back source, NONE skips the write
    typedef enum logic [1:0] {
        RD_NONE,
        RD_FU,
        RD_IMM,
        RD_PC4
    } rd_sel_t;

    // Request into a unit
    typedef struct packed {
        logic                  ena;
        alu_op_t               alu_op;
        logic                  is_store;
        logic [`SECV_XLEN-1:0] src1;
        logic [`SECV_XLEN-1:0] src2;
        logic [`SECV_XLEN-1:0] sdat;
    } funit_in_t;

    // Answer from a unit
    typedef struct packed {
        logic                  rdy;
        logic [`SECV_XLEN-1:0] res;
    } funit_out_t;

    // Idle request for units not selected
    localparam funit_in_t FUNIT_IN_DEFAULT = '0;

endpackage

// ==== rtl/secv_gpr.sv ====
// SEC-V register file
`timescale 1ns/1ps
`include "secv_defines.svh"

module secv_gpr
    import secv_isa_pkg::*;
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  regadr_t               rs1_adr_i,
    output logic [`SECV_XLEN-1:0] rs1_dat_o,
    input  regadr_t               rs2_adr_i,
    output logic [`SECV_XLEN-1:0] rs2_dat_o,
    input  regadr_t               rd_adr_i,
    input  logic [`SECV_XLEN-1:0] rd_dat_i,
    input  logic                  rd_wb_i
);
    logic [`SECV_XLEN-1:0] regs [32];

    // Entry 0 keeps its reset value forever
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int idx = 0; idx < 32; idx++) begin
                regs[idx] <= '0;
            end
        end else if (rd_wb_i && rd_adr_i != '0) begin
            regs[rd_adr_i] <= rd_dat_i;
        end
    end

    // Asynchronous read ports
    assign rs1_dat_o = regs[rs1_adr_i];
    assign rs2_dat_o = regs[rs2_adr_i];

endmodule

// ==== rtl/secv_isa_pkg.sv ====
// SEC-V instruction set types
package secv_isa_pkg;

    // Register number
    typedef logic [4:0] regadr_t;

    // Major opcodes of the kept subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_t;

    // ALU funct3, shared by OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'b000,
        F3_SLL     = 3'b001,
        F3_SLT     = 3'b010,
        F3_XOR     = 3'b100,
        F3_SRL     = 3'b101,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_op_t;

    // Branch conditions kept
    typedef enum logic [2:0] {
        F3_BEQ = 3'b000,
        F3_BNE = 3'b001,
        F3_BLT = 3'b100,
        F3_BGE = 3'b101
    } funct3_br_t;

    // Only full words on the data bus
    localparam logic [2:0] F3_WORD = 3'b010;

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } funct7_t;

    // Instruction formats, MSB first
    typedef struct packed {
        funct7_t    funct7;
        regadr_t    rs2;
        regadr_t    rs1;
        funct3_op_t funct3;
        regadr_t    rd;
        opcode_t    opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        regadr_t     rs1;
        logic [2:0]  funct3;
        regadr_t     rd;
        opcode_t     opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        regadr_t    rs2;
        regadr_t    rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        regadr_t    rs2;
        regadr_t    rs1;
        funct3_br_t funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        regadr_t     rd;
        opcode_t     opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        regadr_t    rd;
        opcode_t    opcode;
    } inst_j_t;

    // One instruction word, six ways to read it
    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_t;

endpackage

// ==== rtl/secv_lsu.sv ====
// SEC-V load/store unit
`timescale 1ns/1ps
`include "secv_defines.svh"

module secv_lsu
    import secv_fu_pkg::*;
(
    input  funit_in_t                   fu_i,
    output funit_out_t                  fu_o,
    // Data bus
    output logic                        dmem_cyc_o,
    output logic                        dmem_stb_o,
    output logic [`SECV_DADR_WIDTH-1:0] dmem_adr_o,
    output logic                        dmem_we_o,
    output logic [`SECV_XLEN-1:0]       dmem_dat_o,
    input  logic [`SECV_XLEN-1:0]       dmem_dat_i,
    input  logic                        dmem_ack_i
);
    logic [`SECV_XLEN-1:0] ea;

    // Base register plus offset
    assign ea = fu_i.src1 + fu_i.src2;

    // Request stays up as long as ena
    assign dmem_cyc_o = fu_i.ena;
    assign dmem_stb_o = fu_i.ena;
    assign dmem_we_o  = fu_i.ena & fu_i.is_store;

    // Address and data quiet while idle
    assign dmem_adr_o = fu_i.ena ? ea[`SECV_DADR_WIDTH-1:0] : '0;
    assign dmem_dat_o = (fu_i.ena && fu_i.is_store) ? fu_i.sdat : '0;

    // Ack finishes the access and carries load data
    assign fu_o.rdy = dmem_ack_i;
    assign fu_o.res = dmem_dat_i;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the SEC-V regression with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_secv -o Vtb_secv

# Output goes to the terminal, grep decides the exit status
./obj_dir/Vtb_secv | tee /dev/stderr | grep "Regression passed" > /dev/null

echo "Simulation run finished"

// ==== sim/tb_secv.sv ====
// SEC-V core testbench
`timescale 1ns/1ps
`include "secv_defines.svh"

module tb_secv;
    localparam int          N_WORDS   = 48;
    localparam int          MAX_INSTR = 200;
    localparam int          MAX_WAIT  = 3;
    localparam int          CLK_NS    = 10;
    localparam logic [31:0] TAIL_PC   = 32'(4 * (N_WORDS - 1));

    // One expected data bus access
    typedef struct packed {
        logic [`SECV_DADR_WIDTH-1:0] adr;
        logic                        we;
        logic [`SECV_XLEN-1:0]       dat;
    } dacc_t;

    logic                        clk_i = 1'b0;
    logic                        rst_i;
    logic                        imem_cyc_o, imem_stb_o, imem_ack_i;
    logic [`SECV_IADR_WIDTH-1:0] imem_adr_o;
    logic [31:0]                 imem_dat_i;
    logic                        dmem_cyc_o, dmem_stb_o, dmem_we_o, dmem_ack_i;
    logic [`SECV_DADR_WIDTH-1:0] dmem_adr_o;
    logic [`SECV_XLEN-1:0]       dmem_dat_o, dmem_dat_i;

    // Program, bus-side data memory, reference model state
    logic [31:0] prog [64];
    logic [31:0] bus_mem [64];
    logic [31:0] mdl_mem [64];
    logic [31:0] xr [32];
    logic [31:0] mdl_pc;
    dacc_t       exp_q [$];
    integer      seed;
    int          iwait, dwait, tail_hits;
    bit          iact, dact;

    secv_core dut_i (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .imem_cyc_o (imem_cyc_o),
        .imem_stb_o (imem_stb_o),
        .imem_adr_o (imem_adr_o),
        .imem_dat_i (imem_dat_i),
        .imem_ack_i (imem_ack_i),
        .dmem_cyc_o (dmem_cyc_o),
        .dmem_stb_o (dmem_stb_o),
        .dmem_adr_o (dmem_adr_o),
        .dmem_we_o  (dmem_we_o),
        .dmem_dat_o (dmem_dat_o),
        .dmem_dat_i (dmem_dat_i),
        .dmem_ack_i (dmem_ack_i)
    );

    always #(CLK_NS / 2) clk_i = ~clk_i;

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    task automatic stop_run;
        $display("Regression failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_fetch(input logic [`SECV_IADR_WIDTH-1:0] got,
                               input logic [`SECV_IADR_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: fetch address %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_data(input logic [`SECV_DADR_WIDTH-1:0] adr, input logic we,
                              input logic [`SECV_XLEN-1:0] dat, input dacc_t exp);
        // Write data only matters for stores
        if (adr !== exp.adr || we !== exp.we || (we && dat !== exp.dat)) begin
            $display("** Error at %0t: data access adr %h we %b dat %h, expected %h %b %h",
                     $time, adr, we, dat, exp.adr, exp.we, exp.dat);
            stop_run();
        end
    endtask

    // Random program over x1..x7, forward control flow only
    task automatic gen_program;
        int          kind, off;
        logic [4:0]  rd, rs1, rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic [6:0]  f7;
        for (int i = 0; i < N_WORDS - 1; i++) begin
            kind = rnd(12);
            rd   = 5'(1 + rnd(7));
            rs1  = 5'(rnd(8));
            rs2  = 5'(rnd(8));
            f3   = 3'(rnd(8));
            imm  = 12'(rnd(4096));
            off  = 8 + 4 * rnd(5);
            // Jumps that would pass the tail become ALU ops
            if ((kind == 5 || kind == 6) && i * 4 + off > int'(TAIL_PC)) begin
                kind = 7;
            end
            if (f3 == 3'b011) begin
                f3 = 3'b000;
            end
            case (kind)
                0: begin
                    // Custom-0 opcode or a byte load, both outside the subset
                    if (rnd(2) == 1) begin
                        prog[i] = {imm, rs1, f3, rd, 7'b0001011};
                    end else begin
                        prog[i] = {imm, rs1, 3'b000, rd, 7'b0000011};
                    end
                end
                1: prog[i] = {20'(rnd(1 << 20)), rd, 7'b0110111};
                2: prog[i] = {4'b0, 6'(rnd(64)), 2'b00, 5'd0, 3'b010, rd, 7'b0000011};
                3, 4: begin
                    imm     = {4'b0, 6'(rnd(64)), 2'b00};
                    prog[i] = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
                end
                5: begin
                    // BEQ, BNE, BLT or BGE
                    f3      = {1'(rnd(2)), 1'b0, 1'(rnd(2))};
                    prog[i] = {1'b0, 6'(off >> 5), rs2, rs1, f3, 4'(off >> 1), 1'b0,
                               7'b1100011};
                end
                6: prog[i] = {1'b0, 10'(off >> 1), 1'b0, 8'b0, rd, 7'b1101111};
                7, 8: begin
                    if (f3 == 3'b001 || f3 == 3'b101) begin
                        imm = {7'b0, imm[4:0]};
                    end
                    prog[i] = {imm, rs1, f3, rd, 7'b0010011};
                end
                default: begin
                    f7      = (f3 == 3'b000 && rnd(2) == 1) ? 7'b0100000 : 7'b0;
                    prog[i] = {f7, rs2, rs1, f3, rd, 7'b0110011};
                end
            endcase
        end
        // JAL x0 to itself
        prog[N_WORDS - 1] = 32'h0000_006f;
        for (int i = N_WORDS; i < 64; i++) begin
            prog[i] = `SECV_INST_NOP;
        end
        for (int a = 0; a < 64; a++) begin
            bus_mem[a] = 32'h3c00_0000 + 32'(a) * 32'h0001_0421;
            mdl_mem[a] = bus_mem[a];
        end
    endtask

    // One instruction of the reference ISA model
    task automatic step_model;
        logic [31:0] w, a, b, res, nxt, ea;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic        wr, taken;
        w     = prog[mdl_pc[7:2]];
        rd    = w[11:7];
        f3    = w[14:12];
        a     = xr[w[19:15]];
        b     = xr[w[24:20]];
        nxt   = mdl_pc + 4;
        res   = '0;
        wr    = 1'b0;
        taken = 1'b0;
        case (w[6:0])
            7'b0110011, 7'b0010011: begin
                if (w[6:0] == 7'b0010011) begin
                    b = sext12(w[31:20]);
                end
                wr = 1'b1;
                case (f3)
                    // Opcode bit 5 tells OP from OP-IMM, only OP has SUB
                    3'b000:  res = (w[5] && w[30]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = {31'b0, $signed(a) < $signed(b)};
                    3'b100:  res = a ^ b;
                    3'b101:  res = a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            7'b0110111: begin
                res = {w[31:12], 12'b0};
                wr  = 1'b1;
            end
            7'b1101111: begin
                res = nxt;
                wr  = 1'b1;
                nxt = mdl_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b1100011: begin
                case (f3)
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    default: taken = ($signed(a) >= $signed(b));
                endcase
                if (taken) begin
                    nxt = mdl_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
                end
            end
            7'b0000011: begin
                // Only full-word loads exist, other widths are illegal
                if (f3 == 3'b010) begin
                    ea  = a + sext12(w[31:20]);
                    exp_q.push_back({ea[`SECV_DADR_WIDTH-1:0], 1'b0, 32'h0});
                    res = mdl_mem[ea[7:2]];
                    wr  = 1'b1;
                end
            end
            7'b0100011: begin
                ea = a + sext12({w[31:25], w[11:7]});
                exp_q.push_back({ea[`SECV_DADR_WIDTH-1:0], 1'b1, b});
                mdl_mem[ea[7:2]] = b;
            end
            // Illegal word, registers untouched
            default: wr = 1'b0;
        endcase
        if (wr && rd != 5'd0) begin
            xr[rd] = res;
        end
        mdl_pc = nxt;
    endtask

    // Instruction memory, 0 to 3 wait cycles
    always @(posedge clk_i) begin
        imem_ack_i <= 1'b0;
        if (!rst_i) begin
            if (iact && !(imem_cyc_o && imem_stb_o)) begin
                $display("Instruction request dropped before ack at %0t", $time);
                stop_run();
            end
            // New request, not the tail of the previous one
            if (imem_cyc_o && imem_stb_o && !iact && !imem_ack_i) begin
                if (exp_q.size() != 0) begin
                    $display("Data access lost before fetch at %0t", $time);
                    stop_run();
                end
                check_fetch(imem_adr_o, mdl_pc[`SECV_IADR_WIDTH-1:0]);
                if (mdl_pc == TAIL_PC) begin
                    tail_hits++;
                end
                step_model();
                iact  = 1'b1;
                iwait = rnd(MAX_WAIT + 1);
            end
            if (iact) begin
                if (iwait == 0) begin
                    imem_dat_i <= prog[imem_adr_o[`SECV_IADR_WIDTH-1:2]];
                    imem_ack_i <= 1'b1;
                    iact = 1'b0;
                end else begin
                    iwait--;
                end
            end
        end
    end

    // Data memory, same wait behavior
    always @(posedge clk_i) begin
        dmem_ack_i <= 1'b0;
        if (!rst_i) begin
            if (dact && !(dmem_cyc_o && dmem_stb_o)) begin
                $display("Data request dropped before ack at %0t", $time);
                stop_run();
            end
            if (dmem_cyc_o && dmem_stb_o && !dact && !dmem_ack_i) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected or repeated data access at %0t", $time);
                    stop_run();
                end
                check_data(dmem_adr_o, dmem_we_o, dmem_dat_o, exp_q.pop_front());
                dact  = 1'b1;
                dwait = rnd(MAX_WAIT + 1);
            end
            if (dact) begin
                if (dwait == 0) begin
                    if (dmem_we_o) begin
                        bus_mem[dmem_adr_o[`SECV_DADR_WIDTH-1:2]] = dmem_dat_o;
                    end
                    dmem_dat_i <= bus_mem[dmem_adr_o[`SECV_DADR_WIDTH-1:2]];
                    dmem_ack_i <= 1'b1;
                    dact = 1'b0;
                end else begin
                    dwait--;
                end
            end
        end
    end

    initial begin
        seed       = 32'h7b12;
        rst_i      = 1'b1;
        imem_ack_i = 1'b0;
        imem_dat_i = '0;
        dmem_ack_i = 1'b0;
        dmem_dat_i = '0;
        iact       = 1'b0;
        dact       = 1'b0;
        tail_hits  = 0;
        mdl_pc     = `SECV_RESET_PC;
        for (int r = 0; r < 32; r++) begin
            xr[r] = '0;
        end
        gen_program();
        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        // Still IDLE, both buses quiet
        @(negedge clk_i);
        if (imem_cyc_o || imem_stb_o || dmem_cyc_o || dmem_stb_o || dmem_we_o) begin
            $display("Bus request active right after reset");
            stop_run();
        end
        // Tail loop reached a few times
        wait (tail_hits >= 3);
        $display("Regression passed");
        $finish;
    end

    // Worst case of 4 cycles plus two full bus waits per instruction
    initial begin
        #(MAX_INSTR * (4 + 2 * MAX_WAIT) * CLK_NS);
        $display("Watchdog timeout, the core stopped making progress");
        stop_run();
    end

endmodule

// ==== vlog.f ====
+incdir+include
rtl/secv_isa_pkg.sv
rtl/secv_fu_pkg.sv
rtl/secv_gpr.sv
rtl/secv_decoder.sv
rtl/secv_alu.sv
rtl/secv_lsu.sv
rtl/secv_core.sv
sim/tb_secv.sv
